/* vlog.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/pipe_reg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/cpu_pipeline.sv
bench/cpu_properties.sv
bench/cpu_tb.sv

/* Makefile */
# Verilator build and run for the five-stage pipeline testbench

SRCS := $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: all run clean

all: obj_dir/Vcpu_tb

obj_dir/Vcpu_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module cpu_tb \
		-Mdir obj_dir -o Vcpu_tb

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/cpu_tb.sv */
// Pipeline testbench
// Memory model, test programs, reference interpreter and commit checker

`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_tb
  import cpu_pkg::*;
;
  logic        clock;
  logic        arst_n;
  logic [31:0] mem2proc_data;
  bus_cmd_e    proc2mem_command;
  logic [31:0] proc2mem_addr, proc2mem_data;
  logic        commit_valid, commit_wr_en, halted;
  logic [4:0]  commit_wr_idx;
  logic [31:0] commit_wr_data, commit_npc;

  logic [31:0] mem [1024];       // DUT side memory
  logic [31:0] image [1024];     // Program image, copied during reset
  logic [31:0] ref_mem [1024];
  logic [31:0] ref_regs [32];
  logic [31:0] ref_pc;
  logic        ref_halted;
  logic [31:0] prog [$];
  int          commits;
  integer      seed = 53194;

  cpu_pipeline u_cpu_pipeline (.*);

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;   // 10 ns period
  end

  ////////////////////
  // Memory model
  assign mem2proc_data = mem[proc2mem_addr[11:2]];   // Same-cycle answer

  always @(posedge clock)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < 1024; i++)
        mem[i] <= image[i];
    end
    else if (proc2mem_command == BUS_STORE)
      mem[proc2mem_addr[11:2]] <= proc2mem_data;
  end

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic report_failure(string what);
    $display("%0t: %s", $time, what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] r_type(logic [5:0] op, logic [4:0] rd, ra, rb);
    return {op, rd, ra, rb, 11'd0};
  endfunction

  function automatic logic [31:0] i_type(logic [5:0] op, logic [4:0] rd, ra,
                                        logic [15:0] imm);
    return {op, rd, ra, imm};
  endfunction

  function automatic logic [15:0] rand_imm();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  ////////////////////
  // Reference interpreter stepping one instruction per call
  function automatic void step_ref(output logic [31:0] npc, output logic wr_en,
                                   output logic [4:0] idx, output logic [31:0] data);
    logic [31:0] inst, a, sext, addr;
    logic [5:0]  opc;
    logic [4:0]  rd;
    inst  = ref_mem[ref_pc[11:2]];
    opc   = inst[31:26];
    rd    = inst[25:21];
    a     = ref_regs[inst[20:16]];
    sext  = {{16{inst[15]}}, inst[15:0]};
    addr  = a + sext;             // Byte address for LD and ST
    npc   = ref_pc + 32'd4;
    ref_pc = npc;
    wr_en = 1'b1;
    idx   = rd;
    data  = '0;
    case (opc)
      OP_ADD:  data = a + ref_regs[inst[15:11]];
      OP_SUB:  data = a - ref_regs[inst[15:11]];
      OP_AND:  data = a & ref_regs[inst[15:11]];
      OP_OR:   data = a | ref_regs[inst[15:11]];
      OP_ADDI: data = addr;
      OP_LD:   data = ref_mem[addr[11:2]];
      default: wr_en = 1'b0;
    endcase
    if (opc == OP_ST)
      ref_mem[addr[11:2]] = ref_regs[rd];   // rd is the data source
    if (opc == OP_BEQZ && a == 32'd0)
      ref_pc = npc + (sext << 2);
    if (opc == OP_HALT)
      ref_halted = 1'b1;
    if (rd == 5'd0)
      wr_en = 1'b0;
    if (wr_en)
      ref_regs[rd] = data;
  endfunction

  // Commit checker on the falling edge where outputs are settled
  always @(negedge clock)
  begin
    logic [31:0] e_npc, e_data;
    logic        e_wr;
    logic [4:0]  e_idx;
    if (arst_n && commit_valid)
    begin
      if (ref_halted)
        report_failure("commit seen after HALT had committed");
      step_ref(e_npc, e_wr, e_idx, e_data);
      commits++;
      check_value("commit_npc", commit_npc, e_npc);
      check_value("commit_wr_en", {31'd0, commit_wr_en}, {31'd0, e_wr});
      if (e_wr)
      begin
        check_value("commit_wr_idx", {27'd0, commit_wr_idx}, {27'd0, e_idx});
        check_value("commit_wr_data", commit_wr_data, e_data);
      end
    end
  end

  ////////////////////
  // Program run with load, reset, halt wait and memory compare
  task automatic run_program(string name);
    int cycles;
    for (int i = 0; i < 1024; i++)
      image[i] = 32'hC000_0000 | (i * 4);   // Opcode 0x30 is a no-op
    for (int i = 0; i < prog.size(); i++)
      image[i] = prog[i];
    for (int i = 0; i < 4; i++)
      image[prog.size() + i] = `NOP_INST;  // Padding behind HALT
    for (int i = 0; i < 1024; i++)
      ref_mem[i] = image[i];
    for (int i = 0; i < 32; i++)
      ref_regs[i] = '0;
    ref_pc     = `RESET_PC;
    ref_halted = 1'b0;
    commits    = 0;
    @(posedge clock);
    arst_n <= 1'b0;
    repeat (16) @(posedge clock);
    arst_n <= 1'b1;
    cycles = 0;
    while (!halted)
    begin
      @(negedge clock);
      cycles++;
      if (cycles > 2000)
        report_failure({"program ", name, " did not halt"});
    end
    if (!ref_halted)
      report_failure({"halted rose before HALT committed in ", name});
    repeat (50) @(negedge clock);     // Checker flags any late commit
    for (int i = 0; i < 1024; i++)
      check_value($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
    $display("%0t: %s done, %0d commits", $time, name, commits);
  endtask

  initial
  begin
    arst_n = 1'b0;
    // Independent ALU ops with random immediates
    prog = {};
    for (int r = 1; r <= 4; r++)
      prog.push_back(i_type(OP_ADDI, 5'(r), 5'd0, rand_imm()));
    repeat (3) prog.push_back(`NOP_INST);
    prog.push_back(r_type(OP_ADD, 5'd5, 5'd1, 5'd2));
    prog.push_back(r_type(OP_SUB, 5'd6, 5'd3, 5'd4));
    prog.push_back(r_type(OP_AND, 5'd7, 5'd1, 5'd3));
    prog.push_back(r_type(OP_OR, 5'd8, 5'd2, 5'd4));
    prog.push_back(i_type(OP_ADDI, 5'd9, 5'd0, rand_imm()));
    prog.push_back({OP_HALT, 26'd0});
    run_program("alu");
    // Dependences at distance 1, 2 and 3
    prog = {};
    prog.push_back(i_type(OP_ADDI, 5'd1, 5'd0, rand_imm()));
    prog.push_back(i_type(OP_ADDI, 5'd2, 5'd1, rand_imm()));
    prog.push_back(r_type(OP_ADD, 5'd3, 5'd1, 5'd2));
    prog.push_back(r_type(OP_SUB, 5'd4, 5'd1, 5'd3));
    prog.push_back(r_type(OP_OR, 5'd5, 5'd2, 5'd4));
    prog.push_back(i_type(OP_ADDI, 5'd0, 5'd0, 16'd9));   // r0 stays zero
    prog.push_back(r_type(OP_ADD, 5'd6, 5'd0, 5'd5));
    prog.push_back({OP_HALT, 26'd0});
    run_program("forward");
    // Store, load and load-use
    prog = {};
    prog.push_back(i_type(OP_ADDI, 5'd1, 5'd0, 16'h0800));
    prog.push_back(i_type(OP_ADDI, 5'd2, 5'd0, rand_imm()));
    prog.push_back(i_type(OP_ST, 5'd2, 5'd1, 16'd4));
    prog.push_back(i_type(OP_LD, 5'd3, 5'd1, 16'd4));
    prog.push_back(r_type(OP_ADD, 5'd4, 5'd3, 5'd3));
    prog.push_back(i_type(OP_LD, 5'd5, 5'd1, 16'd8));
    prog.push_back(r_type(OP_SUB, 5'd6, 5'd5, 5'd3));
    prog.push_back(i_type(OP_ST, 5'd6, 5'd1, 16'd12));
    prog.push_back(i_type(OP_LD, 5'd7, 5'd1, 16'd12));
    prog.push_back({OP_HALT, 26'd0});
    run_program("memory");
    // Not-taken then taken BEQZ skipping three shadow ops
    prog = {};
    prog.push_back(i_type(OP_ADDI, 5'd2, 5'd0, 16'd3));
    prog.push_back(i_type(OP_BEQZ, 5'd0, 5'd2, 16'd5));
    prog.push_back(i_type(OP_BEQZ, 5'd0, 5'd1, 16'd3));
    prog.push_back(i_type(OP_ADDI, 5'd3, 5'd0, 16'd1));
    prog.push_back(i_type(OP_ADDI, 5'd4, 5'd0, 16'd2));
    prog.push_back(i_type(OP_ADDI, 5'd5, 5'd0, 16'd3));
    prog.push_back(i_type(OP_ADDI, 5'd6, 5'd2, 16'd4));   // Branch target
    prog.push_back({OP_HALT, 26'd0});
    run_program("branch");
    $display("Testbench passed");
    $finish;
  end

endmodule

/* bench/cpu_properties.sv */
// Pipeline port checks
// Bound to the top level, halt stickiness, commit index and bus command

`timescale 1ns/100ps

module cpu_properties
  import cpu_pkg::*;
(
  input logic       clock,
  input logic       arst_n,
  input logic       halted,
  input logic       commit_wr_en,
  input logic [4:0] commit_wr_idx,
  input bus_cmd_e   proc2mem_command
);

  ////////////////////
  // Halt is sticky until reset
  a_halt_sticky: assert property (@(posedge clock) disable iff (!arst_n)
    halted |=> halted)
    else $error("halted fell while out of reset");

  // Register zero is never written
  a_wr_idx_nonzero: assert property (@(posedge clock) disable iff (!arst_n)
    commit_wr_en |-> commit_wr_idx != 5'd0)
    else $error("commit_wr_en with index zero");

  // Port always busy, fetch or data
  a_cmd_valid: assert property (@(posedge clock) disable iff (!arst_n)
    proc2mem_command != BUS_NONE)
    else $error("proc2mem_command is BUS_NONE out of reset");

endmodule

bind cpu_pipeline cpu_properties u_cpu_properties (.*);

/* verilog/cpu_pipeline.sv */
// Five-stage in-order pipeline, top level
// Connects the stages and the ID/EX, EX/MEM and MEM/WB registers;
// writeback is the MEM/WB fields driving the register file

`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_pipeline
  import cpu_pkg::*;
(
  input  logic                  clock,
  input  logic                  arst_n,
  input  logic [`XLEN-1:0]      mem2proc_data,
  output bus_cmd_e              proc2mem_command,
  output logic [`XLEN-1:0]      proc2mem_addr,
  output logic [`XLEN-1:0]      proc2mem_data,
  output logic                  commit_valid,
  output logic                  commit_wr_en,
  output logic [`REG_IDX_W-1:0] commit_wr_idx,
  output logic [`XLEN-1:0]      commit_wr_data,
  output logic [`XLEN-1:0]      commit_npc,
  output logic                  halted
);

  logic [`XLEN-1:0] fetch_addr;
  logic [`XLEN-1:0] if_id_npc;
  logic [`XLEN-1:0] if_id_inst;
  logic             if_id_valid;
  logic             squash;        // Branch or HALT, clears younger stages
  logic             stall;         // Load-use bubble
  logic             data_access;
  logic             wb_halt;

  id_ex_t  id_ex_d,  id_ex_q;
  ex_mem_t ex_mem_d, ex_mem_q;
  mem_wb_t mem_wb_d, mem_wb_q;

  ////////////////////
  // Writeback and commit
  assign wb_halt        = mem_wb_q.valid && mem_wb_q.halt;
  assign commit_valid   = mem_wb_q.valid;
  assign commit_wr_en   = mem_wb_q.valid && mem_wb_q.dest != `ZERO_REG;
  assign commit_wr_idx  = mem_wb_q.dest;
  assign commit_wr_data = mem_wb_q.result;
  assign commit_npc     = mem_wb_q.npc;

  fetch_stage u_fetch_stage (
    .clock          (clock),
    .arst_n         (arst_n),
    .stall          (stall),
    .data_access    (data_access),
    .ex_take_branch (ex_mem_q.take_branch),
    .ex_target      (ex_mem_q.alu_result),  // Branch target rides in alu_result
    .wb_halt        (wb_halt),
    .mem_inst       (mem2proc_data),
    .fetch_addr     (fetch_addr),
    .if_id_npc      (if_id_npc),
    .if_id_inst     (if_id_inst),
    .if_id_valid    (if_id_valid),
    .squash         (squash),
    .halted         (halted)
  );

  decode_stage u_decode_stage (
    .clock       (clock),
    .arst_n      (arst_n),
    .if_id_inst  (if_id_inst),
    .if_id_npc   (if_id_npc),
    .if_id_valid (if_id_valid),
    .wr_en       (commit_wr_en),
    .wr_idx      (mem_wb_q.dest),
    .wr_data     (mem_wb_q.result),
    .id_ex_q     (id_ex_q),
    .ex_mem_q    (ex_mem_q),
    .id_ex_d     (id_ex_d),
    .stall       (stall)
  );

  // Stall drops the consumer's copy, IF/ID keeps it
  pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clock (clock), .arst_n (arst_n), .hold (1'b0),
    .flush (stall | squash), .d (id_ex_d), .q (id_ex_q)
  );

  execute_stage u_execute_stage (
    .id_ex_q  (id_ex_q),
    .ex_mem_q (ex_mem_q),
    .mem_wb_q (mem_wb_q),
    .ex_mem_d (ex_mem_d)
  );

  pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clock (clock), .arst_n (arst_n), .hold (1'b0),
    .flush (squash), .d (ex_mem_d), .q (ex_mem_q)
  );

  memory_stage u_memory_stage (
    .ex_mem_q         (ex_mem_q),
    .fetch_addr       (fetch_addr),
    .mem2proc_data    (mem2proc_data),
    .proc2mem_command (proc2mem_command),
    .proc2mem_addr    (proc2mem_addr),
    .proc2mem_data    (proc2mem_data),
    .data_access      (data_access),
    .mem_wb_d         (mem_wb_d)
  );

  // Nothing behind a committing HALT reaches WB
  pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .clock (clock), .arst_n (arst_n), .hold (1'b0),
    .flush (wb_halt), .d (mem_wb_d), .q (mem_wb_q)
  );

endmodule

/* verilog/memory_stage.sv */
// Memory stage
// Drives the shared memory port, data access before fetch,
// and forms the result that goes to MEM/WB

`timescale 1ns/100ps
`include "cpu_defs.svh"

module memory_stage
  import cpu_pkg::*;
(
  input  ex_mem_t          ex_mem_q,
  input  logic [`XLEN-1:0] fetch_addr,
  input  logic [`XLEN-1:0] mem2proc_data,
  output bus_cmd_e         proc2mem_command,
  output logic [`XLEN-1:0] proc2mem_addr,
  output logic [`XLEN-1:0] proc2mem_data,
  output logic             data_access,    // Fetch loses the port
  output mem_wb_t          mem_wb_d
);

  assign data_access = ex_mem_q.valid && (ex_mem_q.rd_mem || ex_mem_q.wr_mem);

  ////////////////////
  // Port arbitration
  always_comb
  begin
    proc2mem_command = BUS_LOAD;         // Instruction fetch by default
    proc2mem_addr    = fetch_addr;
    if (data_access)
    begin
      proc2mem_command = ex_mem_q.wr_mem ? BUS_STORE : BUS_LOAD;
      proc2mem_addr    = ex_mem_q.alu_result;
    end
  end

  assign proc2mem_data = ex_mem_q.st_data;

  // Stage result
  always_comb
  begin
    mem_wb_d        = '0;
    mem_wb_d.npc    = ex_mem_q.npc;
    mem_wb_d.result = ex_mem_q.rd_mem ? mem2proc_data : ex_mem_q.alu_result;
    mem_wb_d.dest   = ex_mem_q.dest;
    mem_wb_d.halt   = ex_mem_q.halt;
    mem_wb_d.valid  = ex_mem_q.valid;
  end

endmodule

/* verilog/execute_stage.sv */
// Execute stage
// Applies the forward selections from decode, runs the ALU
// and resolves BEQZ

`timescale 1ns/100ps
`include "cpu_defs.svh"

module execute_stage
  import cpu_pkg::*;
(
  input  id_ex_t  id_ex_q,
  input  ex_mem_t ex_mem_q,
  input  mem_wb_t mem_wb_q,
  output ex_mem_t ex_mem_d
);

  logic [`XLEN-1:0] opa;
  logic [`XLEN-1:0] opb_reg;    // Forwarded register b, also store data
  logic [`XLEN-1:0] opb;
  logic [`XLEN-1:0] imm_ext;
  logic [`XLEN-1:0] target;
  logic [`XLEN-1:0] alu_out;

  function automatic logic [`XLEN-1:0] fwd_mux(
    input fwd_sel_e         sel,
    input logic [`XLEN-1:0] reg_val,
    input logic [`XLEN-1:0] ex_val,
    input logic [`XLEN-1:0] mem_val
  );
    case (sel)
      EX_FWD:  return ex_val;     // Producer now in EX/MEM
      MEM_FWD: return mem_val;    // Producer now in MEM/WB
      default: return reg_val;
    endcase
  endfunction

  assign opa     = fwd_mux(id_ex_q.fwd_a, id_ex_q.rega, ex_mem_q.alu_result, mem_wb_q.result);
  assign opb_reg = fwd_mux(id_ex_q.fwd_b, id_ex_q.regb, ex_mem_q.alu_result, mem_wb_q.result);

  ////////////////////
  // Operand b and ALU
  assign imm_ext = {{(`XLEN-`IMM_W){id_ex_q.imm[`IMM_W-1]}}, id_ex_q.imm};
  assign target  = id_ex_q.npc + imm_ext * `INST_BYTES;   // Word offset from npc
  assign opb     = id_ex_q.cond_branch ? target :
                   id_ex_q.use_imm     ? imm_ext : opb_reg;

  always_comb
  begin
    case (id_ex_q.alu_op)
      ALU_SUB:    alu_out = opa - opb;
      ALU_AND:    alu_out = opa & opb;
      ALU_OR:     alu_out = opa | opb;
      ALU_PASS_B: alu_out = opb;
      default:    alu_out = opa + opb;     // Also address calc
    endcase
  end

  always_comb
  begin
    ex_mem_d             = '0;
    ex_mem_d.npc         = id_ex_q.npc;
    ex_mem_d.st_data     = opb_reg;
    ex_mem_d.alu_result  = alu_out;
    ex_mem_d.dest        = id_ex_q.dest;
    ex_mem_d.rd_mem      = id_ex_q.rd_mem;
    ex_mem_d.wr_mem      = id_ex_q.wr_mem;
    ex_mem_d.take_branch = id_ex_q.valid && id_ex_q.cond_branch && opa == '0;
    ex_mem_d.halt        = id_ex_q.halt;
    ex_mem_d.valid       = id_ex_q.valid;
  end

endmodule

/* verilog/decode_stage.sv */
// Decode stage
// Register file with write-through, instruction decode,
// forward selection for EX and the load-use stall

`timescale 1ns/100ps
`include "cpu_defs.svh"

module decode_stage
  import cpu_pkg::*;
(
  input  logic                  clock,
  input  logic                  arst_n,
  input  logic [`XLEN-1:0]      if_id_inst,
  input  logic [`XLEN-1:0]      if_id_npc,
  input  logic                  if_id_valid,
  input  logic                  wr_en,      // From MEM/WB
  input  logic [`REG_IDX_W-1:0] wr_idx,
  input  logic [`XLEN-1:0]      wr_data,
  input  id_ex_t                id_ex_q,
  input  ex_mem_t               ex_mem_q,
  output id_ex_t                id_ex_d,
  output logic                  stall
);

  logic [`XLEN-1:0]      regs [`NUM_REGS];
  opcode_e               opcode;
  logic [`REG_IDX_W-1:0] rd_idx, ra_idx, rb_idx;
  logic [`REG_IDX_W-1:0] src_b_idx;   // rb, or rd for ST data
  logic                  use_a, use_b;
  logic                  load_hit_a, load_hit_b;

  assign opcode = opcode_e'(if_id_inst[`OPC_LSB +: `OPC_W]);
  assign rd_idx = if_id_inst[`RD_LSB +: `REG_IDX_W];
  assign ra_idx = if_id_inst[`RA_LSB +: `REG_IDX_W];
  assign rb_idx = if_id_inst[`RB_LSB +: `REG_IDX_W];

  ////////////////////
  // Register file
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < `NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wr_en && wr_idx != `ZERO_REG)
      regs[wr_idx] <= wr_data;
  end

  function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_IDX_W-1:0] idx);
    if (idx == `ZERO_REG)
      return '0;
    else if (wr_en && wr_idx == idx)
      return wr_data;                   // Write-through from WB
    return regs[idx];
  endfunction

  // Younger producer first, WB is covered by write-through
  function automatic fwd_sel_e pick_fwd(input logic used, input logic [`REG_IDX_W-1:0] idx);
    fwd_sel_e sel;
    sel = NO_FWD;
    if (used && idx != `ZERO_REG)
    begin
      if (id_ex_q.valid && id_ex_q.dest == idx)
        sel = EX_FWD;
      else if (ex_mem_q.valid && ex_mem_q.dest == idx)
        sel = MEM_FWD;
    end
    return sel;
  endfunction

  ////////////////////
  // Decoder
  always_comb
  begin
    id_ex_d       = '0;
    use_a         = 1'b0;
    use_b         = 1'b0;
    src_b_idx     = (opcode == OP_ST) ? rd_idx : rb_idx;
    id_ex_d.npc   = if_id_npc;
    id_ex_d.imm   = if_id_inst[`IMM_W-1:0];
    id_ex_d.valid = if_id_valid;
    if (if_id_valid)                    // Bubbles keep all controls low
    begin
      case (opcode)
        OP_ADD, OP_SUB, OP_AND, OP_OR:
        begin
          use_a        = 1'b1;
          use_b        = 1'b1;
          id_ex_d.dest = rd_idx;
          case (opcode)
            OP_SUB:  id_ex_d.alu_op = ALU_SUB;
            OP_AND:  id_ex_d.alu_op = ALU_AND;
            OP_OR:   id_ex_d.alu_op = ALU_OR;
            default: id_ex_d.alu_op = ALU_ADD;
          endcase
        end
        OP_ADDI, OP_LD:
        begin
          use_a           = 1'b1;
          id_ex_d.use_imm = 1'b1;
          id_ex_d.dest    = rd_idx;
          id_ex_d.rd_mem  = (opcode == OP_LD);
        end
        OP_ST:
        begin
          use_a           = 1'b1;       // Base
          use_b           = 1'b1;       // Store data from rd
          id_ex_d.use_imm = 1'b1;
          id_ex_d.wr_mem  = 1'b1;
        end
        OP_BEQZ:
        begin
          use_a               = 1'b1;
          id_ex_d.cond_branch = 1'b1;
          id_ex_d.alu_op      = ALU_PASS_B; // Target comes through operand b
        end
        OP_HALT: id_ex_d.halt = 1'b1;
        default: id_ex_d.dest = `ZERO_REG;  // No-op, commits without a write
      endcase
    end
    id_ex_d.rega  = read_reg(ra_idx);
    id_ex_d.regb  = read_reg(src_b_idx);
    id_ex_d.fwd_a = pick_fwd(use_a, ra_idx);
    id_ex_d.fwd_b = pick_fwd(use_b, src_b_idx);
  end

  // Load in ID/EX feeding a source here
  assign load_hit_a = use_a && ra_idx == id_ex_q.dest;
  assign load_hit_b = use_b && src_b_idx == id_ex_q.dest;
  assign stall      = id_ex_q.valid && id_ex_q.rd_mem && id_ex_q.dest != `ZERO_REG
                      && (load_hit_a || load_hit_b);

endmodule

/* verilog/fetch_stage.sv */
// Fetch stage
// Program counter, IF/ID register, halt flag and the pipeline squash

`timescale 1ns/100ps
`include "cpu_defs.svh"

module fetch_stage
(
  input  logic             clock,
  input  logic             arst_n,
  input  logic             stall,           // Load-use hold of PC and IF/ID
  input  logic             data_access,     // Port taken by MEM
  input  logic             ex_take_branch,  // Taken branch in EX/MEM
  input  logic [`XLEN-1:0] ex_target,
  input  logic             wb_halt,         // HALT committing
  input  logic [`XLEN-1:0] mem_inst,
  output logic [`XLEN-1:0] fetch_addr,
  output logic [`XLEN-1:0] if_id_npc,
  output logic [`XLEN-1:0] if_id_inst,
  output logic             if_id_valid,
  output logic             squash,
  output logic             halted
);

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] pc_plus;
  logic             fetch_go;   // Fetch this cycle lands in IF/ID

  assign fetch_addr = pc;
  assign pc_plus    = pc + `INST_BYTES;
  assign squash     = ex_take_branch | wb_halt;
  assign fetch_go   = !halted && !stall && !data_access;

  ////////////////////
  // PC
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
      pc <= `RESET_PC;
    else if (!halted && !wb_halt)   // Frozen once HALT commits
    begin
      if (ex_take_branch)
        pc <= ex_target;            // Redirect
      else if (fetch_go)
        pc <= pc_plus;
    end
  end

  // Sticky until reset
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
      halted <= 1'b0;
    else if (wb_halt)
      halted <= 1'b1;
  end

  ////////////////////
  // IF/ID register
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      if_id_npc   <= '0;
      if_id_inst  <= `NOP_INST;
      if_id_valid <= 1'b0;
    end
    else if (squash || halted || (data_access && !stall))
    begin
      if_id_npc   <= '0;
      if_id_inst  <= `NOP_INST;
      if_id_valid <= 1'b0;    // Bubble
    end
    else if (!stall)
    begin
      if_id_npc   <= pc_plus;
      if_id_inst  <= mem_inst;
      if_id_valid <= 1'b1;
    end
  end

endmodule

/* verilog/pipe_reg.sv */
// Generic pipeline register
// Carries one stage payload, with hold and a flush to an empty bubble

`timescale 1ns/100ps

module pipe_reg #(
  parameter type payload_t = logic [31:0]
)
(
  input  logic     clock,
  input  logic     arst_n,
  input  logic     hold,    // Keep current contents
  input  logic     flush,   // Load a bubble
  input  payload_t d,
  output payload_t q
);

  // All-zero payload is the bubble
  // valid low, dest on the zero register
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      q <= '0;
    end
    else if (flush)
    begin
      q <= '0;              // Flush wins over hold
    end
    else if (!hold)
    begin
      q <= d;
    end
  end

endmodule

/* verilog/cpu_pkg.sv */
// Types shared by the pipeline stages
// Opcodes, bus commands, forward selects and the stage payload structs

`include "cpu_defs.svh"

package cpu_pkg;

  typedef enum logic [`OPC_W-1:0] {
    OP_NOP  = 6'h00,
    OP_ADD  = 6'h01,
    OP_SUB  = 6'h02,
    OP_AND  = 6'h03,
    OP_OR   = 6'h04,
    OP_ADDI = 6'h05,
    OP_LD   = 6'h08,
    OP_ST   = 6'h09,
    OP_BEQZ = 6'h10,
    OP_HALT = 6'h3f
  } opcode_e;

  typedef enum logic [1:0] {BUS_NONE, BUS_LOAD, BUS_STORE} bus_cmd_e;

  typedef enum logic [1:0] {NO_FWD, EX_FWD, MEM_FWD} fwd_sel_e;

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_PASS_B} alu_op_e;

  ////////////////////
  // Stage payloads
  typedef struct packed {
    logic [`XLEN-1:0]      npc;
    logic [`XLEN-1:0]      rega;        // Base or first operand
    logic [`XLEN-1:0]      regb;        // Second operand or store data
    logic [`IMM_W-1:0]     imm;         // Raw, sign-extended in EX
    logic                  use_imm;
    alu_op_e               alu_op;
    logic [`REG_IDX_W-1:0] dest;
    logic                  rd_mem;
    logic                  wr_mem;
    logic                  cond_branch;
    logic                  halt;
    logic                  valid;
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;
  } id_ex_t;

  typedef struct packed {
    logic [`XLEN-1:0]      npc;
    logic [`XLEN-1:0]      st_data;
    logic [`XLEN-1:0]      alu_result;  // Also branch target
    logic [`REG_IDX_W-1:0] dest;
    logic                  rd_mem;
    logic                  wr_mem;
    logic                  take_branch;
    logic                  halt;
    logic                  valid;
  } ex_mem_t;

  typedef struct packed {
    logic [`XLEN-1:0]      npc;
    logic [`XLEN-1:0]      result;      // Load data or ALU result
    logic [`REG_IDX_W-1:0] dest;
    logic                  halt;
    logic                  valid;
  } mem_wb_t;

endpackage

/* verilog/cpu_defs.svh */
// Width, reset and instruction-format constants
// Shared by the package and every pipeline stage

`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath
`define XLEN        32
`define REG_IDX_W   5
`define NUM_REGS    32
`define IMM_W       16

// Reset and fixed values
`define RESET_PC    32'h0000_0000
`define ZERO_REG    5'd0          // Reads zero, never written
`define NOP_INST    32'h0000_0000

// Instruction fields
`define OPC_LSB     26            // Opcode at [31:26]
`define OPC_W       6
`define RD_LSB      21
`define RA_LSB      16
`define RB_LSB      11

// PC step, one word
`define INST_BYTES  4

`endif
